/* Makefile */
VERILATOR  ?= verilator
TOP        ?= spi_top_tb
LINT_TOP   ?= spi_top
FILELIST   ?= spi_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/spi_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_clk_gen (
	input  wire logic CLK50MHZ,
	input  wire logic RST,
	input  wire logic run,
	output logic      clk_hf,
	output logic      write_trig,
	output logic      read_trig
);

	localparam int unsigned DIV   = `SPI_DIV;
	localparam int unsigned CNT_W = $clog2(DIV + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	// Half period ends on this cycle
	assign wrap = (cnt == LAST);

	////////////////////////////////////////////////////////////////////////////
	// Divider and edge strobes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST || !run) begin
			// Idle phase is clock low, counter at zero
			cnt        <= '0;
			clk_hf     <= 1'b0;
			write_trig <= 1'b0;
			read_trig  <= 1'b0;
		end else begin
			cnt        <= wrap ? '0 : cnt + 1'b1;
			// Strobes line up with the new clock level
			write_trig <= wrap && clk_hf;
			read_trig  <= wrap && !clk_hf;
			if (wrap) begin
				clk_hf <= ~clk_hf;
			end
		end
	end

	// First rising edge lands one half period after run comes up
	a_first_rise: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		$past(run, DIV) && !$past(run, DIV + 1) |-> $rose(clk_hf)
	);

endmodule

`default_nettype wire

/* hdl/spi_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_ctrl (
	input  wire logic               CLK50MHZ,
	input  wire logic               RST,
	input  wire logic               wb_cyc,
	input  wire logic               wb_stb,
	input  wire logic               wb_we,
	input  wire spi_pkg::wb_addr_t  wb_adr,
	input  wire spi_pkg::spi_word_t wb_dat_w,
	input  wire logic               busy,
	input  wire logic               done,
	input  wire spi_pkg::spi_word_t rx_word,
	output spi_pkg::spi_word_t      wb_dat_r,
	output logic                    wb_ack,
	output logic                    start,
	output spi_pkg::spi_word_t      tx_word
);

	logic               req;
	logic               tx_wr;
	logic               rx_rd;
	logic               st_rd;
	logic               done_flag;
	logic               drop_flag;
	spi_pkg::spi_word_t status;
	spi_pkg::spi_word_t rd_mux;

	////////////////////////////////////////////////////////////////////////////
	// Bus decode
	////////////////////////////////////////////////////////////////////////////

	// New request only while ack is low, so accesses never chain
	assign req   = wb_cyc && wb_stb && !wb_ack;
	assign tx_wr = req && wb_we && (wb_adr == `SPI_ADDR_TX);
	assign rx_rd = req && !wb_we && (wb_adr == `SPI_ADDR_RX);
	assign st_rd = req && !wb_we && (wb_adr == `SPI_ADDR_STATUS);

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Transfer start and sticky flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			start <= 1'b0;
		end else begin
			start <= tx_wr && !busy;
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (tx_wr && !busy) begin
			tx_word <= wb_dat_w;
		end
	end

	// Setting wins over a clear in the same cycle
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			done_flag <= 1'b0;
			drop_flag <= 1'b0;
		end else begin
			if (done) begin
				done_flag <= 1'b1;
			end else if (rx_rd) begin
				done_flag <= 1'b0;
			end
			if (tx_wr && busy) begin
				drop_flag <= 1'b1;
			end else if (st_rd) begin
				drop_flag <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		status = '0;
		status[`SPI_ST_BUSY] = busy;
		status[`SPI_ST_DONE] = done_flag;
		status[`SPI_ST_DROP] = drop_flag;
	end

	always_comb begin
		case (wb_adr)
			`SPI_ADDR_RX:     rd_mux = rx_word;
			`SPI_ADDR_STATUS: rd_mux = status;
			default:          rd_mux = '0;
		endcase
	end

	always_ff @(posedge CLK50MHZ) begin
		if (req) begin
			wb_dat_r <= rd_mux;
		end
	end

	a_no_start_busy: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		start |-> !busy
	);

endmodule

`default_nettype wire

/* hdl/spi_params.svh */
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Bits per transfer, also the Wishbone data width
`define SPI_WIDTH 32

// CLK50MHZ cycles per half period of SCK
`define SPI_DIV 4

// Register word addresses
`define SPI_ADDR_TX     2'd0
`define SPI_ADDR_RX     2'd1
`define SPI_ADDR_STATUS 2'd2

// Status register bit positions
`define SPI_ST_BUSY 0
`define SPI_ST_DONE 1
`define SPI_ST_DROP 2

`endif

/* hdl/spi_pkg.sv */
`default_nettype none

`include "spi_params.svh"

package spi_pkg;

	// One transfer word, same width as the bus data
	typedef logic [`SPI_WIDTH-1:0] spi_word_t;

	// Wishbone word address
	typedef logic [1:0] wb_addr_t;

	// Shift engine sequence
	typedef enum logic [1:0] {
		IDLE,
		SENDING,
		DONE
	} shift_state_e;

endpackage

`default_nettype wire

/* hdl/spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_shifter (
	input  wire logic              CLK50MHZ,
	input  wire logic              RST,
	input  wire logic              start,
	input  wire spi_pkg::spi_word_t tx_word,
	input  wire logic              clk_hf,
	input  wire logic              write_trig,
	input  wire logic              read_trig,
	input  wire logic              spi_miso,
	output logic                   busy,
	output logic                   done,
	output spi_pkg::spi_word_t     rx_word,
	output logic                   spi_sck,
	output logic                   spi_cs,
	output logic                   spi_mosi
);

	localparam int unsigned W     = `SPI_WIDTH;
	localparam int unsigned IDX_W = $clog2(W + 3);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(W + 1);

	spi_pkg::shift_state_e state;
	logic [IDX_W-1:0]      idx;
	spi_pkg::spi_word_t    tx_sr;
	spi_pkg::spi_word_t    rx_sr;
	logic                  sck_en;

	// Index 0 and 1 are lead-in strobes, SCK runs for 2 .. W+1
	assign sck_en = (idx > IDX_W'(1)) && (idx <= IDX_LAST);

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= spi_pkg::IDLE;
			idx   <= '0;
		end else begin
			case (state)
				spi_pkg::IDLE: begin
					idx <= '0;
					if (start) begin
						state <= spi_pkg::SENDING;
					end
				end
				spi_pkg::SENDING: begin
					if (write_trig) begin
						idx <= idx + 1'b1;
						if (idx == IDX_LAST) begin
							state <= spi_pkg::DONE;
						end
					end
				end
				default: begin
					state <= spi_pkg::IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == spi_pkg::IDLE && start) begin
			tx_sr <= tx_word;
		end else if (state == spi_pkg::SENDING && write_trig && idx != '0) begin
			tx_sr <= {tx_sr[W-2:0], 1'b0};
		end
		// Sample only on edges the slave actually sees
		if (state == spi_pkg::SENDING && read_trig && sck_en) begin
			rx_sr <= {rx_sr[W-2:0], spi_miso};
		end
	end

	// MOSI moves after SCK falls
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_mosi <= 1'b0;
		end else if (state == spi_pkg::SENDING) begin
			if (write_trig && idx != '0) begin
				spi_mosi <= tx_sr[W-1];
			end
		end else begin
			spi_mosi <= 1'b0;
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_cs <= 1'b1;
		end else if (start) begin
			spi_cs <= 1'b0;
		end else if (done) begin
			spi_cs <= 1'b1;
		end
	end

	assign busy    = (state == spi_pkg::DONE) ? 1'b0 : (state == spi_pkg::SENDING);
	assign done    = (state == spi_pkg::DONE);
	assign rx_word = rx_sr;
	assign spi_sck = sck_en ? clk_hf : 1'b0;

	// Single done cycle, and no new start may hold chip select down
	a_done_pulse: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		done |=> !done && spi_cs
	);

	// SCK comes from the divider, CS from here
	a_sck_in_cs: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		spi_sck |-> !spi_cs
	);

endmodule

`default_nettype wire

/* hdl/spi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_top (
	input  wire logic               CLK50MHZ,
	input  wire logic               RST,
	input  wire logic               wb_cyc,
	input  wire logic               wb_stb,
	input  wire logic               wb_we,
	input  wire spi_pkg::wb_addr_t  wb_adr,
	input  wire spi_pkg::spi_word_t wb_dat_w,
	output spi_pkg::spi_word_t      wb_dat_r,
	output logic                    wb_ack,
	output logic                    spi_sck,
	output logic                    spi_cs,
	output logic                    spi_mosi,
	input  wire logic               spi_miso
);

	logic               start;
	logic               busy;
	logic               done;
	spi_pkg::spi_word_t tx_word;
	spi_pkg::spi_word_t rx_word;
	logic               clk_hf;
	logic               write_trig;
	logic               read_trig;

	spi_ctrl u_ctrl (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.busy     (busy),
		.done     (done),
		.rx_word  (rx_word),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.start    (start),
		.tx_word  (tx_word)
	);

	spi_shifter u_shifter (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.start      (start),
		.tx_word    (tx_word),
		.clk_hf     (clk_hf),
		.write_trig (write_trig),
		.read_trig  (read_trig),
		.spi_miso   (spi_miso),
		.busy       (busy),
		.done       (done),
		.rx_word    (rx_word),
		.spi_sck    (spi_sck),
		.spi_cs     (spi_cs),
		.spi_mosi   (spi_mosi)
	);

	// Serial clock runs only while a transfer is in flight
	spi_clk_gen u_clk_gen (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.run        (busy),
		.clk_hf     (clk_hf),
		.write_trig (write_trig),
		.read_trig  (read_trig)
	);

endmodule

`default_nettype wire

/* spi_top.f */
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_clk_gen.sv
hdl/spi_shifter.sv
hdl/spi_ctrl.sv
hdl/spi_top.sv
tb/spi_top_tb.sv

/* tb/spi_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_top_tb;

	localparam int W          = `SPI_WIDTH;
	localparam int NUM_ROWS   = 8;
	localparam int ACK_LIMIT  = 16;
	localparam int POLL_LIMIT = 200;

	localparam spi_pkg::spi_word_t DROP_TX_A  = 32'hc3a5_0f96;
	localparam spi_pkg::spi_word_t DROP_TX_B  = 32'h0000_ffff;
	localparam spi_pkg::spi_word_t DROP_RESP  = 32'h5a5a_f00f;

	logic               CLK50MHZ;
	logic               RST;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	spi_pkg::wb_addr_t  wb_adr;
	spi_pkg::spi_word_t wb_dat_w;
	spi_pkg::spi_word_t wb_dat_r;
	logic               wb_ack;
	logic               spi_sck;
	logic               spi_cs;
	logic               spi_mosi;
	logic               spi_miso = 1'b0;

	// SPI slave model state
	spi_pkg::spi_word_t slave_resp = '0;
	spi_pkg::spi_word_t miso_sr    = '0;
	spi_pkg::spi_word_t mosi_cap   = '0;
	logic               sck_q      = 1'b0;
	logic               cs_q       = 1'b1;
	int                 rise_cnt   = 0;
	int                 cs_falls   = 0;

	int          err_count   = 0;
	int          check_count = 0;
	int          test_count  = 0;
	int          bad_tests   = 0;
	logic        hung        = 1'b0;
	logic [31:0] lfsr_state  = 32'h6c2b_8677;

	// Stimulus table
	string              row_name [NUM_ROWS];
	spi_pkg::spi_word_t row_tx   [NUM_ROWS];
	spi_pkg::spi_word_t row_resp [NUM_ROWS];

	spi_top uut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	////////////////////////////////////////////////////////////////////////////
	// SPI slave, mode 0, edges seen through the system clock
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK50MHZ) begin
		sck_q <= spi_sck;
		cs_q  <= spi_cs;
		if (RST) begin
			sck_q    <= 1'b0;
			cs_q     <= 1'b1;
			spi_miso <= 1'b0;
		end else if (cs_q && !spi_cs) begin
			// MSB goes out as soon as chip select drops
			cs_falls <= cs_falls + 1;
			rise_cnt <= 0;
			mosi_cap <= '0;
			spi_miso <= slave_resp[W-1];
			miso_sr  <= {slave_resp[W-2:0], 1'b0};
		end else if (!spi_cs) begin
			if (spi_sck && !sck_q) begin
				mosi_cap <= {mosi_cap[W-2:0], spi_mosi};
				rise_cnt <= rise_cnt + 1;
			end
			if (!spi_sck && sck_q) begin
				spi_miso <= miso_sr[W-1];
				miso_sr  <= {miso_sr[W-2:0], 1'b0};
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
	endfunction

	// One LFSR step per bit
	task automatic draw_word(output spi_pkg::spi_word_t w);
		w = '0;
		for (int b = 0; b < W; b++) begin
			w          = {w[W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic build_table();
		row_name[0] = "all_zeros";
		row_tx[0]   = '0;
		row_resp[0] = '0;
		row_name[1] = "all_ones";
		row_tx[1]   = '1;
		row_resp[1] = '1;
		row_name[2] = "alternating";
		row_tx[2]   = 32'haaaa_aaaa;
		row_resp[2] = 32'h5555_5555;
		row_name[3] = "single_msb";
		row_tx[3]   = 32'h8000_0000;
		row_resp[3] = 32'h8000_0000;
		for (int r = 4; r < NUM_ROWS; r++) begin
			row_name[r] = $sformatf("lfsr_%0d", r - 4);
			draw_word(row_tx[r]);
			draw_word(row_resp[r]);
		end
	endtask

	task automatic check_value(input string tag, input spi_pkg::spi_word_t expected,
		input spi_pkg::spi_word_t actual);
		// Values after a stalled bus mean nothing
		if (hung) begin
			return;
		end
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("** Error: %s expected %h actual %h", tag, expected, actual);
		end
	endtask

	// Wishbone classic single access
	task automatic bus_access(input logic we, input spi_pkg::wb_addr_t adr,
		input spi_pkg::spi_word_t wdata, output spi_pkg::spi_word_t rdata);
		int cycles;
		rdata = '0;
		if (hung) begin
			return;
		end
		@(posedge CLK50MHZ);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		cycles = 0;
		@(posedge CLK50MHZ);
		while (!wb_ack && !hung) begin
			cycles++;
			if (cycles > ACK_LIMIT) begin
				$display("Timeout: no Wishbone ack at address %0d", adr);
				hung = 1'b1;
			end else begin
				@(posedge CLK50MHZ);
			end
		end
		rdata = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wait_done(output spi_pkg::spi_word_t st);
		int polls;
		polls = 0;
		st    = '0;
		while (!hung && !st[`SPI_ST_DONE]) begin
			if (polls == POLL_LIMIT) begin
				$display("Timeout: the done status bit never came up");
				hung = 1'b1;
			end else begin
				polls++;
				bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (hung) begin
			bad_tests++;
			$display("%s: stopped by timeout", name);
		end else if (err_count != errs_before) begin
			bad_tests++;
			$display("%s: %0d mismatches", name, err_count - errs_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic run_reset_test();
		int                 errs_before;
		spi_pkg::spi_word_t st;
		errs_before = err_count;
		check_value("reset_state cs", W'(1), W'(spi_cs));
		check_value("reset_state sck", '0, W'(spi_sck));
		bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
		check_value("reset_state status", '0, st);
		report_test("reset_state", errs_before);
	endtask

	task automatic run_transfer(input string name, input spi_pkg::spi_word_t tx,
		input spi_pkg::spi_word_t resp);
		int                 errs_before;
		int                 falls_before;
		spi_pkg::spi_word_t st;
		spi_pkg::spi_word_t rd;
		errs_before  = err_count;
		falls_before = cs_falls;
		check_value({name, " cs idle"}, W'(1), W'(spi_cs));
		slave_resp <= resp;
		bus_access(1'b1, `SPI_ADDR_TX, tx, rd);
		bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
		check_value({name, " busy"}, W'(1), W'(st[`SPI_ST_BUSY]));
		check_value({name, " cs active"}, '0, W'(spi_cs));
		wait_done(st);
		check_value({name, " busy at done"}, '0, W'(st[`SPI_ST_BUSY]));
		check_value({name, " cs after"}, W'(1), W'(spi_cs));
		check_value({name, " cs falls"}, W'(1), W'(cs_falls - falls_before));
		check_value({name, " sck rises"}, W'(W), W'(rise_cnt));
		check_value({name, " mosi word"}, tx, mosi_cap);
		bus_access(1'b0, `SPI_ADDR_RX, '0, rd);
		check_value({name, " rx word"}, resp, rd);
		// Done clears on the receive read
		bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
		check_value({name, " status after rx"}, '0, st);
		report_test(name, errs_before);
	endtask

	task automatic run_drop_test();
		int                 errs_before;
		int                 falls_before;
		spi_pkg::spi_word_t st;
		spi_pkg::spi_word_t rd;
		errs_before  = err_count;
		falls_before = cs_falls;
		slave_resp <= DROP_RESP;
		bus_access(1'b1, `SPI_ADDR_TX, DROP_TX_A, rd);
		// Second write lands while the first word is in flight
		bus_access(1'b1, `SPI_ADDR_TX, DROP_TX_B, rd);
		bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
		check_value("drop_on_busy busy", W'(1), W'(st[`SPI_ST_BUSY]));
		check_value("drop_on_busy drop set", W'(1), W'(st[`SPI_ST_DROP]));
		bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
		check_value("drop_on_busy drop cleared", '0, W'(st[`SPI_ST_DROP]));
		wait_done(st);
		check_value("drop_on_busy cs falls", W'(1), W'(cs_falls - falls_before));
		check_value("drop_on_busy sck rises", W'(W), W'(rise_cnt));
		check_value("drop_on_busy mosi word", DROP_TX_A, mosi_cap);
		bus_access(1'b0, `SPI_ADDR_RX, '0, rd);
		check_value("drop_on_busy rx word", DROP_RESP, rd);
		bus_access(1'b0, `SPI_ADDR_STATUS, '0, st);
		check_value("drop_on_busy status after rx", '0, st);
		report_test("drop_on_busy", errs_before);
	endtask

	initial begin
		RST      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		build_table();
		repeat (10) @(posedge CLK50MHZ);
		RST <= 1'b0;
		@(posedge CLK50MHZ);
		run_reset_test();
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_transfer(row_name[i], row_tx[i], row_resp[i]);
		end
		run_drop_test();
		$display("tests %0d, failing tests %0d, checks %0d, errors %0d",
			test_count, bad_tests, check_count, err_count);
		if (!hung && err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
